// ==== dv/nand_cmd_props.sv ====
`timescale 1ns/1ps

module nand_cmd_props (
    input logic i_Clk,
    input logic i_Rst_L,
    input logic i_cmd_dv,
    input logic o_cmd_ready,
    input logic o_feature_dv,
    input logic o_spi_clk,
    input logic o_spi_cs_n
);

    // Host strobe lands while ready is high, then chip select drops one cycle later
    a_cs_fall_on_cmd: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
        $fell(o_spi_cs_n) |-> $past(i_cmd_dv) && $past(o_cmd_ready, 2))
        else $error("chip select fell without an accepted host command");

    a_busy_while_selected: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
        !o_spi_cs_n |-> !o_cmd_ready)
        else $error("command ready was high while chip select was low");

    // Mode 3 clock parks high between frames
    a_clk_idle_high: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
        o_spi_cs_n |-> o_spi_clk)
        else $error("SPI clock was low while chip select was high");

    a_feature_single: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
        o_feature_dv |=> !o_feature_dv)
        else $error("feature strobe stayed high for two cycles");

endmodule

// ==== dv/nand_cmd_tb.sv ====
`timescale 1ns/1ps
`include "nand_consts.svh"

module nand_cmd_tb
    import nand_cmd_pkg::*;
();

    localparam int NUM_CMDS       = 60;
    localparam int RST_CYCLES     = 16;
    localparam int BYTE_CLKS      = 16 * `NAND_CLKS_PER_HALF_BIT;    // 64 clocks per byte
    localparam int TIMEOUT_CYCLES = NUM_CMDS * (`NAND_MAX_CMD_BYTES * BYTE_CLKS + 20) + 200;

    logic       i_Clk = 1'b0;
    logic       i_Rst_L;
    logic       i_cmd_dv;
    nand_cmd_t  i_cmd;
    logic       i_spi_miso;
    logic       o_cmd_ready;
    logic       o_feature_dv;
    logic [7:0] o_feature_byte;
    logic       o_spi_clk;
    logic       o_spi_mosi;
    logic       o_spi_cs_n;

    nand_cmd_t  pending_q[$];        // Commands driven with no frame seen yet
    logic [7:0] frame_bytes[$];      // MOSI bytes of the open frame
    logic       prev_cs_n  = 1'b1;
    logic       prev_sclk  = 1'b1;
    logic [7:0] miso_byte  = 8'h00;  // Flash answer drawn per frame
    logic [2:0] miso_bit   = 3'd7;
    logic [7:0] mosi_shift = 8'h00;
    logic [2:0] mosi_bits  = 3'd0;
    logic [7:0] last_op    = 8'h00;  // Opcode of the last closed frame
    logic [7:0] last_miso  = 8'h00;
    int         feature_seen = 0;
    int         frame_cnt    = 0;
    int         err_cnt      = 0;
    int         check_cnt    = 0;
    int         cycle_cnt    = 0;

    always #50 i_Clk = ~i_Clk;       // 100 ns period

    nand_cmd_ctrl u_dut (
        .i_Clk          (i_Clk),
        .i_Rst_L        (i_Rst_L),
        .i_cmd_dv       (i_cmd_dv),
        .i_cmd          (i_cmd),
        .o_cmd_ready    (o_cmd_ready),
        .o_feature_dv   (o_feature_dv),
        .o_feature_byte (o_feature_byte),
        .o_spi_clk      (o_spi_clk),
        .o_spi_mosi     (o_spi_mosi),
        .i_spi_miso     (i_spi_miso),
        .o_spi_cs_n     (o_spi_cs_n)
    );

    bind nand_cmd_ctrl nand_cmd_props u_props (
        .i_Clk        (i_Clk),
        .i_Rst_L      (i_Rst_L),
        .i_cmd_dv     (i_cmd_dv),
        .o_cmd_ready  (o_cmd_ready),
        .o_feature_dv (o_feature_dv),
        .o_spi_clk    (o_spi_clk),
        .o_spi_cs_n   (o_spi_cs_n)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_cnt++;
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            err_cnt++;
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d, frames: %0d", check_cnt, err_cnt, frame_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    // Feature commands take 3 bytes, row address commands 4 and all else 1
    function automatic int expected_len(input logic [7:0] op);
        if (op == GET_FEATURE || op == SET_FEATURE)
            return 3;
        if (op == PAGE_READ || op == CACHE_REQ_PAGE || op == CACHE_LAST ||
            op == PROG_EXEC || op == BLOCK_ERASE)
            return 4;
        return 1;
    endfunction

    // Frame bytes in shift order with the first byte in the top lane and unused lanes zero
    function automatic logic [31:0] expected_frame(input nand_cmd_t cmd);
        if (cmd.opcode == SET_FEATURE)
            return {cmd.opcode, cmd.addr_data[15:8], cmd.addr_data[7:0], 8'h00};
        if (cmd.opcode == GET_FEATURE)
            return {cmd.opcode, cmd.addr_data[15:8], 16'h0000};   // Zero byte while chip answers
        if (expected_len(cmd.opcode) == 4)
            return {cmd.opcode, cmd.addr_data};                   // Address MSB first
        return {cmd.opcode, 24'h000000};
    endfunction

    // A GET_FEATURE frame owes exactly one feature strobe
    task automatic settle_feature_count();
        if (last_op == GET_FEATURE)
            check_value("feature_strobes", feature_seen, 32'd1);
        last_op = 8'h00;
    endtask

    task automatic close_frame();
        nand_cmd_t   cmd;
        logic [31:0] exp;
        int          i;
        frame_cnt++;
        if (pending_q.size() == 0) begin
            $display("ERROR: chip select framed bytes with no command pending");
            err_cnt++;
        end else begin
            cmd = pending_q.pop_front();
            exp = expected_frame(cmd);
            check_value("frame_len", frame_bytes.size(), expected_len(cmd.opcode));
            for (i = 0; i < frame_bytes.size() && i < expected_len(cmd.opcode); i++) begin
                check_value("o_spi_mosi byte", {24'h0, frame_bytes[i]}, {24'h0, exp[31:24]});
                exp = exp << 8;
            end
            last_op      = cmd.opcode;
            last_miso    = miso_byte;
            feature_seen = 0;
        end
    endtask

    task automatic check_feature();
        if (last_op != GET_FEATURE) begin
            $display("ERROR: feature strobe after a command other than GET_FEATURE");
            err_cnt++;
        end else begin
            check_value("o_feature_byte", {24'h0, o_feature_byte}, {24'h0, last_miso});
        end
        feature_seen++;
    endtask

    // Flash model and checker that see SPI edges one system clock late
    always @(posedge i_Clk) begin
        if (i_Rst_L) begin
            if (prev_cs_n && !o_spi_cs_n) begin
                settle_feature_count();
                miso_byte  = 8'($urandom);             // New answer per frame
                miso_bit   = 3'd7;
                mosi_bits  = 3'd0;
                frame_bytes.delete();
            end
            if (!o_spi_cs_n && prev_sclk && !o_spi_clk) begin
                i_spi_miso <= miso_byte[miso_bit];     // MSB first ahead of the sample edge
                miso_bit = miso_bit - 3'd1;
            end
            if (!prev_sclk && o_spi_clk) begin
                mosi_shift = {mosi_shift[6:0], o_spi_mosi};
                mosi_bits  = mosi_bits + 3'd1;
                if (mosi_bits == 3'd0)
                    frame_bytes.push_back(mosi_shift);
            end
            if (!prev_cs_n && o_spi_cs_n)
                close_frame();                          // Last rise handled above
            if (o_feature_dv)
                check_feature();
            prev_cs_n = o_spi_cs_n;
            prev_sclk = o_spi_clk;
        end
    end

    always @(posedge i_Clk) begin
        cycle_cnt++;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("ERROR: timeout after %0d cycles, the engine stopped finishing commands",
                     cycle_cnt);
            err_cnt++;
            finish_run();
        end
    end

    initial begin
        nand_cmd_t cmd;
        int        idle;
        int        n;
        void'($urandom(74883));
        i_Rst_L    <= 1'b0;
        i_cmd_dv   <= 1'b0;
        i_cmd      <= '0;
        i_spi_miso <= 1'b1;
        repeat (RST_CYCLES) @(posedge i_Clk);
        i_Rst_L <= 1'b1;

        // Quiet bus with no stimulus
        repeat (20) begin
            @(posedge i_Clk);
            check_value("o_spi_cs_n", {31'b0, o_spi_cs_n}, 32'd1);
            check_value("o_spi_clk", {31'b0, o_spi_clk}, 32'd1);
            check_value("o_cmd_ready", {31'b0, o_cmd_ready}, 32'd1);
            check_value("o_feature_dv", {31'b0, o_feature_dv}, 32'd0);
        end

        for (n = 0; n < NUM_CMDS; n++) begin
            if ($urandom % 4 == 0)
                cmd.opcode = 8'($urandom);              // Often an unknown opcode
            else
                case ($urandom % 10)
                    0: cmd.opcode = RESET;
                    1: cmd.opcode = WRITE_ENABLE;
                    2: cmd.opcode = WRITE_DISABLE;
                    3: cmd.opcode = GET_FEATURE;
                    4: cmd.opcode = SET_FEATURE;
                    5: cmd.opcode = PAGE_READ;
                    6: cmd.opcode = CACHE_REQ_PAGE;
                    7: cmd.opcode = CACHE_LAST;
                    8: cmd.opcode = PROG_EXEC;
                    default: cmd.opcode = BLOCK_ERASE;
                endcase
            cmd.addr_data = 24'($urandom);
            idle = $urandom % 6;
            repeat (idle) @(posedge i_Clk);
            @(posedge i_Clk);
            while (!o_cmd_ready)
                @(posedge i_Clk);
            i_cmd_dv <= 1'b1;
            i_cmd    <= cmd;
            pending_q.push_back(cmd);
            @(posedge i_Clk);
            i_cmd_dv <= 1'b0;                           // Single-cycle strobe
        end

        while (frame_cnt < NUM_CMDS || !o_cmd_ready)
            @(posedge i_Clk);
        repeat (10) @(posedge i_Clk);                   // Room for a late feature strobe
        settle_feature_count();
        check_value("frame_count", frame_cnt, NUM_CMDS);
        check_value("pending_cmds", pending_q.size(), 32'd0);
        finish_run();
    end

endmodule

// ==== flist.f ====
+incdir+source
source/nand_cmd_pkg.sv
source/spi_link_pkg.sv
source/nand_cmd_sequencer.sv
source/spi_byte_master.sv
source/nand_cmd_ctrl.sv
dv/nand_cmd_props.sv
dv/nand_cmd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the NAND command engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module nand_cmd_tb -f flist.f -o nand_cmd_sim

status=0
./obj_dir/nand_cmd_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "Verification passed" sim.log; then
    exit 0
fi
exit 1

// ==== source/nand_cmd_ctrl.sv ====
`timescale 1ns/1ps
`include "nand_consts.svh"

module nand_cmd_ctrl
    import nand_cmd_pkg::*;
    import spi_link_pkg::*;
(
    input  logic                    i_Clk,
    input  logic                    i_Rst_L,
    input  logic                    i_cmd_dv,
    input  nand_cmd_t               i_cmd,
    output logic                    o_cmd_ready,
    output logic                    o_feature_dv,
    output logic [`NAND_BYTE_W-1:0] o_feature_byte,
    output logic                    o_spi_clk,
    output logic                    o_spi_mosi,
    input  logic                    i_spi_miso,
    output logic                    o_spi_cs_n
);

    spi_tx_t w_tx;          // Bytes toward the chip
    spi_rx_t w_rx;          // Bytes back from the chip
    logic    w_tx_ready;

    nand_cmd_sequencer u_seq (
        .i_Clk          (i_Clk),
        .i_Rst_L        (i_Rst_L),
        .i_cmd_dv       (i_cmd_dv),
        .i_cmd          (i_cmd),
        .i_tx_ready     (w_tx_ready),
        .o_tx           (w_tx),
        .i_rx           (w_rx),
        .o_cmd_ready    (o_cmd_ready),
        .o_feature_dv   (o_feature_dv),
        .o_feature_byte (o_feature_byte)
    );

    spi_byte_master #(
        .CLKS_PER_HALF_BIT (`NAND_CLKS_PER_HALF_BIT)
    ) u_spi (
        .i_Clk      (i_Clk),
        .i_Rst_L    (i_Rst_L),
        .i_tx       (w_tx),
        .o_tx_ready (w_tx_ready),
        .o_rx       (w_rx),
        .o_spi_clk  (o_spi_clk),
        .o_spi_mosi (o_spi_mosi),
        .i_spi_miso (i_spi_miso),
        .o_spi_cs_n (o_spi_cs_n)
    );

endmodule

// ==== source/nand_cmd_pkg.sv ====
`include "nand_consts.svh"

package nand_cmd_pkg;

    // Opcodes of the serial NAND command set handled by the engine
    // Anything outside this list goes out as a lone opcode byte
    typedef enum logic [`NAND_BYTE_W-1:0] {
        RESET          = 8'hFF, // One byte
        WRITE_ENABLE   = 8'h06, // One byte
        WRITE_DISABLE  = 8'h04, // One byte
        GET_FEATURE    = 8'h0F, // Opcode, feature addr, dummy byte while chip returns data
        SET_FEATURE    = 8'h1F, // Opcode, feature addr, feature data
        PAGE_READ      = 8'h13, // Opcode + 24-bit row address
        CACHE_REQ_PAGE = 8'h30, // Opcode + 24-bit row address
        CACHE_LAST     = 8'h3F, // Opcode + 24-bit row address
        PROG_EXEC      = 8'h10, // Opcode + 24-bit row address
        BLOCK_ERASE    = 8'hD8  // Opcode + 24-bit row address
    } nand_opcode_e;

    // Host command, valid with its single-cycle strobe
    // Feature commands: address in [15:8], data in [7:0]
    typedef struct packed {
        logic [`NAND_BYTE_W-1:0] opcode;    // Raw byte so unknown opcodes pass through
        logic [`NAND_ADDR_W-1:0] addr_data;
    } nand_cmd_t;

endpackage

// ==== source/nand_cmd_sequencer.sv ====
`timescale 1ns/1ps
`include "nand_consts.svh"

module nand_cmd_sequencer
    import nand_cmd_pkg::*;
    import spi_link_pkg::*;
(
    input  logic                    i_Clk,
    input  logic                    i_Rst_L,
    input  logic                    i_cmd_dv,       // Single-cycle command strobe
    input  nand_cmd_t               i_cmd,
    input  logic                    i_tx_ready,     // Shifter can take a byte
    output spi_tx_t                 o_tx,
    input  spi_rx_t                 i_rx,
    output logic                    o_cmd_ready,
    output logic                    o_feature_dv,
    output logic [`NAND_BYTE_W-1:0] o_feature_byte
);

    localparam int CNT_W = $clog2(`NAND_MAX_CMD_BYTES + 1);

    logic                    r_busy;     // Command in flight
    nand_cmd_t               r_cmd;      // Latched host command
    logic [CNT_W-1:0]        r_len;      // Bytes in this command
    logic [CNT_W-1:0]        r_tx_cnt;   // Bytes offered so far
    logic [CNT_W-1:0]        r_rx_cnt;   // Bytes finished by the shifter
    logic                    r_tx_stb;
    logic                    r_tx_last;
    logic [`NAND_BYTE_W-1:0] r_tx_data;
    logic                    w_idle;
    logic                    w_accept;
    logic                    w_next;     // Offer the following byte
    logic                    w_feature;  // Third byte of a GET_FEATURE frame

    // Frame length by opcode
    function automatic logic [CNT_W-1:0] cmd_len(input logic [`NAND_BYTE_W-1:0] op);
        case (op)
            GET_FEATURE, SET_FEATURE:
                cmd_len = CNT_W'(3);
            PAGE_READ, CACHE_REQ_PAGE, CACHE_LAST, PROG_EXEC, BLOCK_ERASE:
                cmd_len = CNT_W'(`NAND_MAX_CMD_BYTES);
            default:
                cmd_len = CNT_W'(1);                    // Resets, write enables, unknowns
        endcase
    endfunction

    // Byte at position idx, opcode excluded (idx starts at 1)
    function automatic logic [`NAND_BYTE_W-1:0] cmd_byte(input nand_cmd_t cmd,
                                                         input logic [CNT_W-1:0] idx);
        logic [`NAND_BYTE_W-1:0] b;
        b = '0;
        case (cmd.opcode)
            SET_FEATURE, GET_FEATURE: begin
                if (idx == CNT_W'(1))
                    b = cmd.addr_data[15:8];            // Feature register address
                else if (cmd.opcode == SET_FEATURE)
                    b = cmd.addr_data[7:0];             // Value to write
                // GET_FEATURE clocks a zero byte while the chip answers
            end
            PAGE_READ, CACHE_REQ_PAGE, CACHE_LAST, PROG_EXEC, BLOCK_ERASE: begin
                case (idx)
                    CNT_W'(1): b = cmd.addr_data[23:16];
                    CNT_W'(2): b = cmd.addr_data[15:8];
                    default:   b = cmd.addr_data[7:0];
                endcase
            end
            default: b = '0;
        endcase
        return b;
    endfunction

    assign w_idle      = ~r_busy & i_tx_ready;       // Shifter also past its deselect gap
    assign w_accept    = w_idle & i_cmd_dv;
    assign o_cmd_ready = w_idle & ~i_cmd_dv;         // Drops as soon as a strobe lands

    // Skip the cycle right after a strobe, ready is still high there
    assign w_next = r_busy & i_tx_ready & ~r_tx_stb & (r_tx_cnt < r_len);

    assign w_feature = r_busy & i_rx.stb & (r_cmd.opcode == GET_FEATURE)
                     & (r_rx_cnt == CNT_W'(2));

    assign o_tx = '{stb: r_tx_stb, data: r_tx_data, last: r_tx_last};

    always_ff @(posedge i_Clk or negedge i_Rst_L) begin
        if (!i_Rst_L) begin
            r_busy       <= 1'b0;
            r_len        <= '0;
            r_tx_cnt     <= '0;
            r_rx_cnt     <= '0;
            r_tx_stb     <= 1'b0;
            r_tx_last    <= 1'b0;
            o_feature_dv <= 1'b0;
        end else begin
            r_tx_stb     <= 1'b0;                    // Strobes last one cycle
            o_feature_dv <= w_feature;
            if (w_accept) begin
                r_busy    <= 1'b1;
                r_len     <= cmd_len(i_cmd.opcode);
                r_tx_cnt  <= CNT_W'(1);              // Opcode goes out right away
                r_rx_cnt  <= '0;
                r_tx_stb  <= 1'b1;
                r_tx_last <= (cmd_len(i_cmd.opcode) == CNT_W'(1));
            end else if (r_busy) begin
                if (w_next) begin
                    r_tx_stb  <= 1'b1;
                    r_tx_last <= (r_tx_cnt == r_len - CNT_W'(1));
                    r_tx_cnt  <= r_tx_cnt + CNT_W'(1);
                end
                if (i_rx.stb) begin
                    r_rx_cnt <= r_rx_cnt + CNT_W'(1);
                    // Done once the final byte has shifted through
                    if (r_rx_cnt == r_len - CNT_W'(1))
                        r_busy <= 1'b0;
                end
            end
        end
    end

    // Payload path
    always_ff @(posedge i_Clk) begin
        if (w_accept) begin
            r_cmd     <= i_cmd;
            r_tx_data <= i_cmd.opcode;
        end else if (w_next) begin
            r_tx_data <= cmd_byte(r_cmd, r_tx_cnt);
        end
        if (w_feature)
            o_feature_byte <= i_rx.data;             // Held until the next GET_FEATURE
    end

endmodule

// ==== source/nand_consts.svh ====
`ifndef NAND_CONSTS_SVH
`define NAND_CONSTS_SVH

// SPI clock timing
`define NAND_CLKS_PER_HALF_BIT 4   // System clocks per SPI half period
`define NAND_CS_GAP_CLKS       2   // Min clocks with chip select high between commands

// Field widths
`define NAND_BYTE_W            8
`define NAND_ADDR_W            24  // Address or address+data carried with the opcode

// Longest command: opcode plus three address bytes
`define NAND_MAX_CMD_BYTES     4

`endif

// ==== source/spi_byte_master.sv ====
`timescale 1ns/1ps
`include "nand_consts.svh"

module spi_byte_master
    import spi_link_pkg::*;
#(
    parameter int CLKS_PER_HALF_BIT = `NAND_CLKS_PER_HALF_BIT
) (
    input  logic    i_Clk,
    input  logic    i_Rst_L,
    input  spi_tx_t i_tx,
    output logic    o_tx_ready,
    output spi_rx_t o_rx,
    output logic    o_spi_clk,      // Mode 3, idles high
    output logic    o_spi_mosi,
    input  logic    i_spi_miso,
    output logic    o_spi_cs_n
);

    localparam int DIV_W  = $clog2(CLKS_PER_HALF_BIT + 1);
    localparam int EDGES  = 2 * `NAND_BYTE_W;            // Fall and rise per bit
    localparam int EDGE_W = $clog2(EDGES + 1);
    localparam int GAP_W  = $clog2(`NAND_CS_GAP_CLKS + 1);

    typedef enum logic [1:0] {
        IDLE,       // Chip deselected, waiting for a first byte
        ACTIVE,     // Chip select low, bytes shifting
        GAP         // Chip select high, holding off the next command
    } cs_state_e;

    cs_state_e               r_state;
    logic                    r_cs_n;
    logic                    r_ready;
    logic                    r_spi_clk;
    logic                    r_mosi;
    logic                    r_last;     // Current byte ends the frame
    logic                    r_rx_stb;
    logic [DIV_W-1:0]        r_div;      // Half-bit divider
    logic [EDGE_W-1:0]       r_edges;    // SPI clock edges left in the byte
    logic [GAP_W-1:0]        r_gap;
    logic [`NAND_BYTE_W-1:0] r_tx_shift;
    logic [`NAND_BYTE_W-1:0] r_rx_shift;
    logic                    w_load;
    logic                    w_tick;
    logic                    w_fall;
    logic                    w_rise;
    logic                    w_done;

    assign w_load = i_tx.stb & r_ready;
    assign w_tick = (r_edges != '0) & (r_div == DIV_W'(CLKS_PER_HALF_BIT - 1));
    assign w_fall = w_tick & r_spi_clk;                  // Launch edge
    assign w_rise = w_tick & ~r_spi_clk;                 // Sample edge
    assign w_done = w_rise & (r_edges == EDGE_W'(1));    // Eighth bit sampled here

    assign o_tx_ready = r_ready;
    assign o_rx       = '{stb: r_rx_stb, data: r_rx_shift};
    assign o_spi_clk  = r_spi_clk;
    assign o_spi_mosi = r_mosi;
    // Select the chip in the same cycle the first byte is offered
    assign o_spi_cs_n = r_cs_n & ~w_load;

    always_ff @(posedge i_Clk or negedge i_Rst_L) begin
        if (!i_Rst_L) begin
            r_state   <= IDLE;
            r_cs_n    <= 1'b1;
            r_ready   <= 1'b1;
            r_spi_clk <= 1'b1;
            r_mosi    <= 1'b1;
            r_last    <= 1'b0;
            r_rx_stb  <= 1'b0;
            r_div     <= '0;
            r_edges   <= '0;
            r_gap     <= '0;
        end else begin
            r_rx_stb <= w_done;

            // Bit timing
            if (w_load) begin
                r_ready <= 1'b0;
                r_edges <= EDGE_W'(EDGES);
                r_div   <= '0;
                r_last  <= i_tx.last;
            end else if (r_edges != '0) begin
                if (w_tick) begin
                    r_div     <= '0;
                    r_spi_clk <= ~r_spi_clk;
                    r_edges   <= r_edges - EDGE_W'(1);
                end else begin
                    r_div <= r_div + DIV_W'(1);
                end
            end

            if (w_fall)
                r_mosi <= r_tx_shift[`NAND_BYTE_W-1];    // MSB first

            // Chip select framing
            case (r_state)
                IDLE: begin
                    if (w_load) begin
                        r_state <= ACTIVE;
                        r_cs_n  <= 1'b0;
                    end
                end
                ACTIVE: begin
                    if (w_done) begin
                        if (r_last) begin
                            r_state <= GAP;
                            r_cs_n  <= 1'b1;
                            r_gap   <= GAP_W'(`NAND_CS_GAP_CLKS - 1);
                        end else begin
                            r_ready <= 1'b1;             // Next byte, CS stays low
                        end
                    end
                end
                GAP: begin
                    if (r_gap == '0) begin
                        r_ready <= 1'b1;
                        r_state <= IDLE;
                    end else begin
                        r_gap <= r_gap - GAP_W'(1);
                    end
                end
                default: r_state <= IDLE;
            endcase
        end
    end

    // Shift registers
    always_ff @(posedge i_Clk) begin
        if (w_load)
            r_tx_shift <= i_tx.data;
        else if (w_fall)
            r_tx_shift <= r_tx_shift << 1;
        if (w_rise)
            r_rx_shift <= {r_rx_shift[`NAND_BYTE_W-2:0], i_spi_miso};
    end

endmodule

// ==== source/spi_link_pkg.sv ====
`include "nand_consts.svh"

package spi_link_pkg;

    // Sequencer to shifter, one byte per strobe
    typedef struct packed {
        logic                    stb;  // Only while shifter is ready
        logic [`NAND_BYTE_W-1:0] data; // Sent MSB first
        logic                    last; // Deselect chip after this byte
    } spi_tx_t;

    // Shifter to sequencer, one strobe per finished byte
    typedef struct packed {
        logic                    stb;
        logic [`NAND_BYTE_W-1:0] data; // Byte captured from MISO
    } spi_rx_t;

endpackage
